// ==== adc/adc_input.sv ====
module adc_input (
    input  logic                 clk160,
    input  logic                 rst_n,
    input  video_pkg::colour_t   hw_rgb_in,
    input  logic                 hw_pixel_strobe,
    input  logic                 hw_hsync_in,
    input  logic                 hw_vsync_in,
    output video_pkg::fifo_word_t fifo_write_data,
    output logic                 fifo_write_request
);
    import video_pkg::*;

    adc_state_t state;
    adc_state_t state_next;
    coord_t     x_cnt;
    coord_t     y_cnt;
    coord_t     y_sel;
    logic       first_line;
    logic       active_sample;
    logic       line_start;

    // Strobed sample with both syncs inactive, once a frame has begun
    assign active_sample = hw_pixel_strobe && hw_hsync_in && hw_vsync_in &&
                           (state != WAIT_FRAME);

    // First active sample after blanking opens a line
    assign line_start = active_sample && (state == BLANK);

    // Row for this sample, bumped on every line after the first of the frame
    assign y_sel = (line_start && !first_line) ? y_cnt + 1'b1 : y_cnt;

    // FSM moves only on strobed samples
    always_comb begin
        state_next = state;
        if (hw_pixel_strobe) begin
            case (state)
                WAIT_FRAME: if (!hw_vsync_in) state_next = BLANK;
                BLANK:      if (hw_hsync_in && hw_vsync_in) state_next = ACTIVE;
                ACTIVE:     if (!(hw_hsync_in && hw_vsync_in)) state_next = BLANK;
                default:    state_next = WAIT_FRAME;
            endcase
        end
    end

    always_ff @(posedge clk160 or negedge rst_n) begin
        if (!rst_n) begin
            state              <= WAIT_FRAME;
            x_cnt              <= '0;
            y_cnt              <= '0;
            first_line         <= 1'b1;
            fifo_write_request <= 1'b0;
        end else begin
            state              <= state_next;
            fifo_write_request <= active_sample;
            // Column restarts on every hsync low
            if (!hw_hsync_in)
                x_cnt <= '0;
            else if (active_sample)
                x_cnt <= x_cnt + 1'b1;
            // Row restarts on vsync low
            if (!hw_vsync_in) begin
                y_cnt      <= '0;
                first_line <= 1'b1;
            end else if (line_start) begin
                y_cnt      <= y_sel;
                first_line <= 1'b0;
            end
        end
    end

    // Pack x, y and colour in FIFO word order
    always_ff @(posedge clk160) begin
        if (active_sample)
            fifo_write_data <= {x_cnt, y_sel, hw_rgb_in};
    end

    // Nothing is written until a vsync low has been seen
    a_no_write_before_frame: assert property (
        @(posedge clk160) disable iff (!rst_n)
        fifo_write_request |-> (state != WAIT_FRAME)
    );

endmodule

// ==== all.f ====
+incdir+common
common/video_pkg.sv
common/pixel_if.sv
adc/adc_input.sv
fifo/pixel_fifo.sv
hdl/overlay_pipeline.sv
dac/dac_handle.sv
hdl/top.sv
tb/tb_top.sv

// ==== common/pixel_if.sv ====
interface pixel_if;
    import video_pkg::*;

    // Pixel strobe for this cycle
    logic    valid;

    // Pixel colour and its position in the frame
    colour_t colour;
    coord_t  x;
    coord_t  y;

    // Producer side
    modport source (
        output valid,
        output colour,
        output x,
        output y
    );

    // Consumer side
    modport sink (
        input valid,
        input colour,
        input x,
        input y
    );

endinterface

// ==== common/video_defines.svh ====
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// RGB565 colour width
`define PIX_W 16

// Pixel x and y position width
`define COORD_W 11

// Entries in the pixel FIFO
`define FIFO_DEPTH 16

// Foreground window size in pixels
`define FG_W 4
`define FG_H 2

// Active frame size seen by the DAC stage
`define H_ACTIVE 8
`define V_ACTIVE 4

`endif

// ==== common/video_pkg.sv ====
`include "video_defines.svh"

package video_pkg;

    // One RGB565 pixel
    typedef logic [`PIX_W-1:0] colour_t;

    // Pixel x or y position
    typedef logic [`COORD_W-1:0] coord_t;

    // FIFO word is x, then y, then colour from the top bit down
    typedef logic [2*`COORD_W+`PIX_W-1:0] fifo_word_t;

    // Overlay modes
    typedef enum logic [1:0] {
        MODE_PASS   = 2'd0,
        MODE_INVERT = 2'd1,
        MODE_FILL   = 2'd2,
        MODE_BLEND  = 2'd3
    } overlay_mode_t;

    // ADC decoder FSM
    typedef enum logic [1:0] {
        WAIT_FRAME = 2'd0,
        ACTIVE     = 2'd1,
        BLANK      = 2'd2
    } adc_state_t;

endpackage

// ==== dac/dac_handle.sv ====
`include "video_defines.svh"

module dac_handle (
    input  logic               clk160,
    input  logic               rst_n,
    pixel_if.sink              pix_in,
    output video_pkg::colour_t hw_colour_bus,
    output logic               hw_hsync_out,
    output logic               hw_vsync_out,
    output logic               hw_dacclk_out
);
    import video_pkg::*;

    // Last active column and row
    localparam coord_t LAST_X = coord_t'(`H_ACTIVE - 1);
    localparam coord_t LAST_Y = coord_t'(`V_ACTIVE - 1);

    logic line_end;
    logic frame_end;

    assign line_end  = (pix_in.x == LAST_X);
    assign frame_end = line_end && (pix_in.y == LAST_Y);

    always_ff @(posedge clk160 or negedge rst_n) begin
        if (!rst_n) begin
            hw_colour_bus <= '0;
            hw_hsync_out  <= 1'b0;
            hw_vsync_out  <= 1'b0;
            hw_dacclk_out <= 1'b0;
        end else if (pix_in.valid) begin
            hw_colour_bus <= pix_in.colour;
            // One DAC clock edge per pixel
            hw_dacclk_out <= ~hw_dacclk_out;
            // Sync pulses ride with the last pixel of a line or frame
            hw_hsync_out  <= line_end;
            hw_vsync_out  <= frame_end;
        end else begin
            // Colour bus holds its last pixel between strobes
            hw_hsync_out  <= 1'b0;
            hw_vsync_out  <= 1'b0;
        end
    end

    // Line sync is a single-cycle pulse
    a_hsync_one_cycle: assert property (
        @(posedge clk160) disable iff (!rst_n)
        hw_hsync_out |=> !hw_hsync_out
    );

endmodule

// ==== fifo/pixel_fifo.sv ====
`include "video_defines.svh"

module pixel_fifo (
    input  logic                  clk160,
    input  logic                  rst_n,
    input  video_pkg::fifo_word_t wr_data,
    input  logic                  wr_en,
    pixel_if.source               rd_port,
    output logic                  overflow
);
    import video_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`FIFO_DEPTH - 1);

    fifo_word_t       mem [`FIFO_DEPTH];
    fifo_word_t       head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             not_empty;
    logic             full;
    logic             push;
    logic             pop;

    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(`FIFO_DEPTH));
    assign push      = wr_en && !full;
    // Head is consumed in every cycle it is shown
    assign pop       = not_empty;

    // Storage
    always_ff @(posedge clk160) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk160 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Dropped write stays flagged until reset
            if (wr_en && full)
                overflow <= 1'b1;
        end
    end

    // Unpack head word onto the pixel bus
    assign head           = mem[rd_ptr];
    assign rd_port.valid  = not_empty;
    assign rd_port.x      = head[`PIX_W+2*`COORD_W-1 -: `COORD_W];
    assign rd_port.y      = head[`PIX_W+`COORD_W-1 -: `COORD_W];
    assign rd_port.colour = head[`PIX_W-1:0];

    a_count_bound: assert property (
        @(posedge clk160) disable iff (!rst_n)
        count <= CNT_W'(`FIFO_DEPTH)
    );

endmodule

// ==== hdl/overlay_pipeline.sv ====
`include "video_defines.svh"

module overlay_pipeline (
    input  logic                     clk160,
    input  logic                     rst_n,
    pixel_if.sink                    pix_in,
    pixel_if.source                  pix_out,
    input  video_pkg::overlay_mode_t ctrl_overlay_mode,
    input  video_pkg::coord_t        ctrl_fg_offset_x,
    input  video_pkg::coord_t        ctrl_fg_offset_y,
    input  video_pkg::colour_t       ctrl_fg_colour
);
    import video_pkg::*;

    // Window size widened by one bit so the far edge cannot wrap
    localparam logic [`COORD_W:0] FG_W_EXT = (`COORD_W+1)'(`FG_W);
    localparam logic [`COORD_W:0] FG_H_EXT = (`COORD_W+1)'(`FG_H);

    logic [`COORD_W:0] x_end;
    logic [`COORD_W:0] y_end;
    logic              in_win;
    logic              s1_valid;
    logic              s1_in_win;
    colour_t           s1_colour;
    coord_t            s1_x;
    coord_t            s1_y;
    colour_t           ovl_colour;

    // Per-channel floor average of two RGB565 pixels
    function automatic colour_t blend(input colour_t a, input colour_t b);
        logic [5:0] r_sum;
        logic [6:0] g_sum;
        logic [5:0] b_sum;
        r_sum = {1'b0, a[15:11]} + {1'b0, b[15:11]};
        g_sum = {1'b0, a[10:5]} + {1'b0, b[10:5]};
        b_sum = {1'b0, a[4:0]} + {1'b0, b[4:0]};
        return {r_sum[5:1], g_sum[6:1], b_sum[5:1]};
    endfunction

    // Window edges, exclusive at the far side
    assign x_end  = {1'b0, ctrl_fg_offset_x} + FG_W_EXT;
    assign y_end  = {1'b0, ctrl_fg_offset_y} + FG_H_EXT;
    assign in_win = (pix_in.x >= ctrl_fg_offset_x) && ({1'b0, pix_in.x} < x_end) &&
                    (pix_in.y >= ctrl_fg_offset_y) && ({1'b0, pix_in.y} < y_end);

    // Stage one registers the pixel and its window flag
    always_ff @(posedge clk160 or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= pix_in.valid;
    end

    always_ff @(posedge clk160) begin
        s1_in_win <= in_win;
        s1_colour <= pix_in.colour;
        s1_x      <= pix_in.x;
        s1_y      <= pix_in.y;
    end

    // Colour rewrite
    always_comb begin
        case (ctrl_overlay_mode)
            MODE_PASS:   ovl_colour = s1_colour;
            // Invert covers the whole frame
            MODE_INVERT: ovl_colour = ~s1_colour;
            MODE_FILL:   ovl_colour = s1_in_win ? ctrl_fg_colour : s1_colour;
            MODE_BLEND:  ovl_colour = s1_in_win ? blend(s1_colour, ctrl_fg_colour) : s1_colour;
            default:     ovl_colour = s1_colour;
        endcase
    end

    // Stage two registers the result
    always_ff @(posedge clk160 or negedge rst_n) begin
        if (!rst_n)
            pix_out.valid <= 1'b0;
        else
            pix_out.valid <= s1_valid;
    end

    always_ff @(posedge clk160) begin
        pix_out.colour <= ovl_colour;
        pix_out.x      <= s1_x;
        pix_out.y      <= s1_y;
    end

    a_two_cycle_latency: assert property (
        @(posedge clk160) disable iff (!rst_n)
        pix_out.valid == $past(pix_in.valid, 2)
    );

endmodule

// ==== hdl/top.sv ====
module top (
    input  logic                     clk160,
    input  logic                     rst_n,

    // ADC input
    input  video_pkg::colour_t       colour_bus_1,
    input  logic                     pixel_strobe_1,
    input  logic                     hsin_1,
    input  logic                     vsin_1,

    // Overlay controls
    input  video_pkg::overlay_mode_t ctrl_overlay_mode,
    input  video_pkg::coord_t        ctrl_fg_offset_x,
    input  video_pkg::coord_t        ctrl_fg_offset_y,
    input  video_pkg::colour_t       ctrl_fg_colour,

    // DAC output
    output video_pkg::colour_t       colour_bus_0,
    output logic                     hsync_out_0,
    output logic                     vsync_out_0,
    output logic                     dacclk_out_0,
    output logic                     fifo_overflow
);
    import video_pkg::*;

    fifo_word_t adc_fifo_data;
    logic       adc_fifo_wr;

    // FIFO head and overlay result
    pixel_if fifo_pix ();
    pixel_if ovl_pix ();

    adc_input adc (
        .clk160             (clk160),
        .rst_n              (rst_n),
        .hw_rgb_in          (colour_bus_1),
        .hw_pixel_strobe    (pixel_strobe_1),
        .hw_hsync_in        (hsin_1),
        .hw_vsync_in        (vsin_1),
        .fifo_write_data    (adc_fifo_data),
        .fifo_write_request (adc_fifo_wr)
    );

    pixel_fifo adc_fifo (
        .clk160   (clk160),
        .rst_n    (rst_n),
        .wr_data  (adc_fifo_data),
        .wr_en    (adc_fifo_wr),
        .rd_port  (fifo_pix),
        .overflow (fifo_overflow)
    );

    overlay_pipeline pipeline (
        .clk160            (clk160),
        .rst_n             (rst_n),
        .pix_in            (fifo_pix),
        .pix_out           (ovl_pix),
        .ctrl_overlay_mode (ctrl_overlay_mode),
        .ctrl_fg_offset_x  (ctrl_fg_offset_x),
        .ctrl_fg_offset_y  (ctrl_fg_offset_y),
        .ctrl_fg_colour    (ctrl_fg_colour)
    );

    dac_handle dac (
        .clk160        (clk160),
        .rst_n         (rst_n),
        .pix_in        (ovl_pix),
        .hw_colour_bus (colour_bus_0),
        .hw_hsync_out  (hsync_out_0),
        .hw_vsync_out  (vsync_out_0),
        .hw_dacclk_out (dacclk_out_0)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_top -o tb_top \
    && ./obj_dir/tb_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// ==== tb/tb_top.sv ====
`include "video_defines.svh"

module tb_top;
    import video_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 20;
    localparam int BLANK_SAMPLES  = 2;
    localparam int BURST_LINE     = 24;
    localparam int SETTLE_CYCLES  = 8;
    localparam int EXP_AW         = 9;
    // Strobe every other cycle in a normal frame, every cycle in the burst
    localparam int FRAME_CYCLES   = `V_ACTIVE * (BLANK_SAMPLES + `H_ACTIVE) * 2;
    localparam int BURST_CYCLES   = `V_ACTIVE * (BLANK_SAMPLES + BURST_LINE);
    localparam int TEST_CYCLES    = IDLE_CYCLES + 6 * FRAME_CYCLES + BURST_CYCLES +
                                    6 * SETTLE_CYCLES;
    localparam int TIMEOUT_CYCLES = (3 * TEST_CYCLES) / 2 + RESET_CYCLES;

    logic          clk160;
    logic          rst_n;
    colour_t       colour_bus_1;
    logic          pixel_strobe_1;
    logic          hsin_1;
    logic          vsin_1;
    overlay_mode_t ctrl_overlay_mode;
    coord_t        ctrl_fg_offset_x;
    coord_t        ctrl_fg_offset_y;
    colour_t       ctrl_fg_colour;
    colour_t       colour_bus_0;
    logic          hsync_out_0;
    logic          vsync_out_0;
    logic          dacclk_out_0;
    logic          fifo_overflow;

    // Reference model storage, written in send order
    colour_t           exp_colour_mem [0:(1<<EXP_AW)-1];
    logic              exp_hs_mem [0:(1<<EXP_AW)-1];
    logic              exp_vs_mem [0:(1<<EXP_AW)-1];
    logic [EXP_AW-1:0] wr_idx;
    logic [EXP_AW-1:0] rd_idx;
    colour_t           exp_head;
    logic              exp_hs;
    logic              exp_vs;

    logic [15:0] lfsr_state;
    logic        dac_seen;
    logic        dac_toggle;
    logic        seen_active;
    int          toggles;
    int          hsync_count;
    int          vsync_count;
    int          errors;
    int          tests_run;
    int          cycles;

    top uut (
        .clk160            (clk160),
        .rst_n             (rst_n),
        .colour_bus_1      (colour_bus_1),
        .pixel_strobe_1    (pixel_strobe_1),
        .hsin_1            (hsin_1),
        .vsin_1            (vsin_1),
        .ctrl_overlay_mode (ctrl_overlay_mode),
        .ctrl_fg_offset_x  (ctrl_fg_offset_x),
        .ctrl_fg_offset_y  (ctrl_fg_offset_y),
        .ctrl_fg_colour    (ctrl_fg_colour),
        .colour_bus_0      (colour_bus_0),
        .hsync_out_0       (hsync_out_0),
        .vsync_out_0       (vsync_out_0),
        .dacclk_out_0      (dacclk_out_0),
        .fifo_overflow     (fifo_overflow)
    );

    always #2 clk160 = ~clk160;

    // Head of the expected stream
    assign exp_head   = exp_colour_mem[rd_idx];
    assign exp_hs     = exp_hs_mem[rd_idx];
    assign exp_vs     = exp_vs_mem[rd_idx];
    // New pixel on the DAC since the last falling edge
    assign dac_toggle = rst_n && (dacclk_out_0 != dac_seen);

    // Outputs are sampled on the falling edge, away from DUT updates
    always @(negedge clk160) begin
        if (dac_toggle) begin
            dac_seen <= dacclk_out_0;
            rd_idx   <= rd_idx + 1'b1;
            toggles  <= toggles + 1;
        end
        if (rst_n && hsync_out_0)
            hsync_count <= hsync_count + 1;
        if (rst_n && vsync_out_0)
            vsync_count <= vsync_count + 1;
    end

    // Run limit
    always @(posedge clk160) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped producing pixels", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Quiet outputs until the first active sample goes in
    a_idle_after_reset: assert property (
        @(negedge clk160) disable iff (!rst_n)
        !seen_active |-> (colour_bus_0 == '0 && !hsync_out_0 && !vsync_out_0 &&
                          !dacclk_out_0 && !fifo_overflow)
    ) else begin
        $display("Outputs left their reset values before any active sample at %0t", $time);
        errors = errors + 1;
    end

    a_colour: assert property (
        @(negedge clk160) disable iff (!rst_n)
        dac_toggle |-> (colour_bus_0 == exp_head)
    ) else begin
        $display("MISMATCH at %0t: colour_bus_0 %h, expected %h", $time,
                 $sampled(colour_bus_0), $sampled(exp_head));
        errors = errors + 1;
    end

    a_pixel_was_sent: assert property (
        @(negedge clk160) disable iff (!rst_n)
        dac_toggle |-> (rd_idx < wr_idx)
    ) else begin
        $display("The DAC produced a pixel that was never sent, at %0t", $time);
        errors = errors + 1;
    end

    a_hsync: assert property (
        @(negedge clk160) disable iff (!rst_n)
        dac_toggle |-> (hsync_out_0 == exp_hs)
    ) else begin
        $display("MISMATCH at %0t: hsync_out_0 %b, expected %b", $time,
                 $sampled(hsync_out_0), $sampled(exp_hs));
        errors = errors + 1;
    end

    a_vsync: assert property (
        @(negedge clk160) disable iff (!rst_n)
        dac_toggle |-> (vsync_out_0 == exp_vs)
    ) else begin
        $display("MISMATCH at %0t: vsync_out_0 %b, expected %b", $time,
                 $sampled(vsync_out_0), $sampled(exp_vs));
        errors = errors + 1;
    end

    a_sync_with_pixel: assert property (
        @(negedge clk160) disable iff (!rst_n)
        (hsync_out_0 || vsync_out_0) |-> dac_toggle
    ) else begin
        $display("A sync pulse came without a pixel at %0t", $time);
        errors = errors + 1;
    end

    // FIFO drains one word per cycle, so it never fills
    a_no_overflow: assert property (
        @(negedge clk160) disable iff (!rst_n)
        !fifo_overflow
    ) else begin
        $display("The FIFO overflow flag was set at %0t", $time);
        errors = errors + 1;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 16'hB400;
        return out_bit;
    endfunction

    function automatic colour_t random_colour();
        colour_t c;
        c = '0;
        for (int i = 0; i < `PIX_W; i++)
            c = {c[`PIX_W-2:0], lfsr_bit()};
        return c;
    endfunction

    function automatic logic in_window(input int x, input int y);
        return (x >= int'(ctrl_fg_offset_x)) && (x < int'(ctrl_fg_offset_x) + `FG_W) &&
               (y >= int'(ctrl_fg_offset_y)) && (y < int'(ctrl_fg_offset_y) + `FG_H);
    endfunction

    // Overlay rules applied to one sent pixel
    function automatic colour_t expected_colour(input colour_t c, input int x, input int y);
        int r;
        int g;
        int b;
        int fg;
        fg = int'(ctrl_fg_colour);
        case (ctrl_overlay_mode)
            MODE_INVERT: return ~c;
            MODE_FILL:   return in_window(x, y) ? ctrl_fg_colour : c;
            MODE_BLEND: begin
                if (!in_window(x, y))
                    return c;
                // Channel averages, integer division rounds down
                r = ((int'(c) / 2048) + (fg / 2048)) / 2;
                g = (((int'(c) / 32) % 64) + ((fg / 32) % 64)) / 2;
                b = ((int'(c) % 32) + (fg % 32)) / 2;
                return colour_t'(r * 2048 + g * 32 + b);
            end
            default:     return c;
        endcase
    endfunction

    task automatic push_expected(input colour_t c, input int x, input int y);
        exp_colour_mem[wr_idx] = expected_colour(c, x, y);
        exp_hs_mem[wr_idx]     = (x == `H_ACTIVE - 1);
        exp_vs_mem[wr_idx]     = (x == `H_ACTIVE - 1) && (y == `V_ACTIVE - 1);
        wr_idx = wr_idx + 1'b1;
    endtask

    // One strobed ADC sample, followed by gap idle cycles
    task automatic drive_sample(input logic hs, input logic vs, input colour_t c,
                                input int gap);
        @(posedge clk160);
        #1;
        pixel_strobe_1 = 1'b1;
        hsin_1         = hs;
        vsin_1         = vs;
        colour_bus_1   = c;
        repeat (gap) begin
            @(posedge clk160);
            #1;
            pixel_strobe_1 = 1'b0;
        end
    endtask

    task automatic send_frame(input int line_len, input int gap);
        colour_t c;
        for (int y = 0; y < `V_ACTIVE; y++) begin
            // Blanking with hsync low, vsync low on the first line only
            for (int i = 0; i < BLANK_SAMPLES; i++)
                drive_sample(1'b0, (y != 0), '0, gap);
            for (int x = 0; x < line_len; x++) begin
                c = random_colour();
                drive_sample(1'b1, 1'b1, c, gap);
                push_expected(c, x, y);
                seen_active = 1'b1;
            end
        end
        @(posedge clk160);
        #1;
        pixel_strobe_1 = 1'b0;
    endtask

    task automatic run_test(input string name, input overlay_mode_t mode, input int ox,
                            input int oy, input colour_t fg, input int frames,
                            input int line_len, input int gap);
        int err_start;
        int tog_start;
        int hs_start;
        int vs_start;
        int pix;
        err_start   = errors;
        tog_start   = toggles;
        hs_start    = hsync_count;
        vs_start    = vsync_count;
        pix         = frames * `V_ACTIVE * line_len;
        // Controls change only while the pipeline is empty
        @(posedge clk160);
        #1;
        ctrl_overlay_mode = mode;
        ctrl_fg_offset_x  = coord_t'(ox);
        ctrl_fg_offset_y  = coord_t'(oy);
        ctrl_fg_colour    = fg;
        for (int f = 0; f < frames; f++)
            send_frame(line_len, gap);
        while (rd_idx != wr_idx)
            @(posedge clk160);
        // Quiet spell so a stray extra pixel or sync still gets counted
        repeat (SETTLE_CYCLES) @(posedge clk160);
        assert (toggles - tog_start == pix) else begin
            $display("MISMATCH at %0t: %0d DAC clock toggles, expected %0d", $time,
                     toggles - tog_start, pix);
            errors = errors + 1;
        end
        assert (hsync_count - hs_start == frames * `V_ACTIVE) else begin
            $display("MISMATCH at %0t: %0d hsync pulses, expected %0d", $time,
                     hsync_count - hs_start, frames * `V_ACTIVE);
            errors = errors + 1;
        end
        assert (vsync_count - vs_start == frames) else begin
            $display("MISMATCH at %0t: %0d vsync pulses, expected %0d", $time,
                     vsync_count - vs_start, frames);
            errors = errors + 1;
        end
        tests_run = tests_run + 1;
        $display("test %s: %0d pixels, %0d errors", name, pix, errors - err_start);
    endtask

    initial begin
        clk160            = 1'b0;
        rst_n             = 1'b0;
        colour_bus_1      = '0;
        pixel_strobe_1    = 1'b0;
        hsin_1            = 1'b1;
        vsin_1            = 1'b1;
        ctrl_overlay_mode = MODE_PASS;
        ctrl_fg_offset_x  = '0;
        ctrl_fg_offset_y  = '0;
        ctrl_fg_colour    = '0;
        lfsr_state        = 16'd47;
        wr_idx            = '0;
        rd_idx            = '0;
        dac_seen          = 1'b0;
        seen_active       = 1'b0;
        toggles           = 0;
        hsync_count       = 0;
        vsync_count       = 0;
        errors            = 0;
        tests_run         = 0;
        cycles            = 0;
        repeat (RESET_CYCLES) @(posedge clk160);
        #1;
        rst_n = 1'b1;

        // Idle outputs are watched by the reset assertion
        repeat (IDLE_CYCLES) @(posedge clk160);
        tests_run = tests_run + 1;
        $display("test reset_idle: %0d errors", errors);

        run_test("pass", MODE_PASS, 0, 0, '0, 2, `H_ACTIVE, 1);
        run_test("invert", MODE_INVERT, 0, 0, '0, 1, `H_ACTIVE, 1);
        run_test("fill", MODE_FILL, 2, 1, 16'h07E0, 1, `H_ACTIVE, 1);
        // Window at the far corner of the frame
        run_test("blend", MODE_BLEND, 4, 2, 16'hF81F, 1, `H_ACTIVE, 1);
        run_test("sync", MODE_PASS, 0, 0, '0, 1, `H_ACTIVE, 1);
        // Back-to-back strobes on long lines
        run_test("burst", MODE_PASS, 0, 0, '0, 1, BURST_LINE, 0);

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
